//--- gen_bus_cfg.svh
// Bus widths, refresh period and region constants, included by the bus core RTL
`ifndef GEN_BUS_CFG_SVH
`define GEN_BUS_CFG_SVH

// Word address covers 68000 address bits 23 to 1
`define GEN_ADDR_W 23
`define GEN_DATA_W 16

// Refresh request interval in MCLK cycles
`define GEN_REFRESH_PERIOD 384

// Open-bus latch value out of reset (a NOP opcode)
`define GEN_OPEN_BUS_INIT 16'h4E71

// Z80 work RAM, 8 KB
`define GEN_ZRAM_AW 13

// Bank register holds 68000 address bits 23 to 15
`define GEN_BANK_W 9

// Region bases, compared against the top address bits
`define GEN_ZBUS_BASE 8'hA0
`define GEN_CTRL_BASE 12'hA11
`define GEN_FDC_BASE 16'hA120
// Z80 7F00h-7FFFh lands here
`define GEN_VDP_WIN 16'hC000

`endif

//--- gen_bus_pkg.sv
// State and source types shared by the MBUS arbiter and the ZBUS controller
package gen_bus_pkg;

	// Main bus arbiter states
	typedef enum logic [3:0] {
		MBUS_IDLE,
		MBUS_SELECT,
		MBUS_RAM_WAIT,
		MBUS_RAM_READ,
		MBUS_RAM_WRITE,
		MBUS_ROM_READ,
		MBUS_ZBUS_READ,
		MBUS_FDC_READ,
		MBUS_NOT_USED,
		MBUS_REFRESH,
		MBUS_FINISH
	} mbus_state_t;

	// Owner of the current MBUS cycle
	typedef enum logic [1:0] {
		SRC_NONE,
		SRC_M68K,
		SRC_Z80
	} mbus_src_t;

	typedef enum logic [1:0] {
		ZBUS_IDLE,
		ZBUS_READ,
		ZBUS_FINISH
	} zbus_state_t;

	typedef enum logic {
		ZSRC_MBUS,
		ZSRC_Z80
	} zbus_src_t;

endpackage

//--- mbus_if.sv
// Arbitrated MBUS cycle from the arbiter to the ZBUS controller, with its replies
`timescale 1ns/1ps
`include "gen_bus_cfg.svh"

interface mbus_if;
	logic [`GEN_ADDR_W:1]   addr;
	logic [`GEN_DATA_W-1:0] wdata;
	logic                   rnw;
	logic                   uds_n;
	logic                   lds_n;
	// Held for the whole ZBUS window cycle
	logic                   zbus_sel;
	// One-cycle strobe for the control registers
	logic                   ctrl_sel;
	logic [7:0]             zbus_rdata;
	logic                   zbus_dtack_n;
	// Combinational decode of the control offsets
	logic                   ctrl_hit;
	logic                   ctrl_flag;

	modport arbiter (
		output addr, wdata, rnw, uds_n, lds_n, zbus_sel, ctrl_sel,
		input  zbus_rdata, zbus_dtack_n, ctrl_hit, ctrl_flag
	);

	modport zbus (
		input  addr, wdata, rnw, uds_n, lds_n, zbus_sel, ctrl_sel,
		output zbus_rdata, zbus_dtack_n, ctrl_hit, ctrl_flag
	);

endinterface

//--- z80_ext_if.sv
// Z80 requests into 68000 space from the ZBUS controller to the arbiter, and completions
`timescale 1ns/1ps
`include "gen_bus_cfg.svh"

interface z80_ext_if;
	// Held while the Z80 access lasts
	logic                   ext_req;
	logic [`GEN_ADDR_W:1]   ext_addr;
	logic [`GEN_DATA_W-1:0] ext_wdata;
	// Even Z80 address, upper byte lane
	logic                   ext_upper;
	logic                   ext_rnw;
	logic [`GEN_DATA_W-1:0] ext_rdata;
	logic                   ext_dtack_n;

	modport zbus (
		output ext_req, ext_addr, ext_wdata, ext_upper, ext_rnw,
		input  ext_rdata, ext_dtack_n
	);

	modport arbiter (
		input  ext_req, ext_addr, ext_wdata, ext_upper, ext_rnw,
		output ext_rdata, ext_dtack_n
	);

endinterface

//--- zram.sv
// Single-port byte RAM with registered read, holding the Z80 work memory
`timescale 1ns/1ps
`include "gen_bus_cfg.svh"

module zram (
	input  logic                    MCLK,
	input  logic [`GEN_ZRAM_AW-1:0] addr,
	input  logic [7:0]              wdata,
	input  logic                    we,
	output logic [7:0]              rdata
);

	logic [7:0] mem [0:(1 << `GEN_ZRAM_AW) - 1];

	// Read returns the old contents on a write cycle
	always_ff @(posedge MCLK) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

//--- mbus_arbiter.sv
// Main bus arbiter with region decode, refresh timer and open-bus latch, used by the top level
`timescale 1ns/1ps
`include "gen_bus_cfg.svh"

module mbus_arbiter (
	input  logic                   MCLK,
	input  logic                   reset,
	input  logic [`GEN_ADDR_W:1]   m68k_a,
	input  logic [`GEN_DATA_W-1:0] m68k_do,
	input  logic                   m68k_as_n,
	input  logic                   m68k_uds_n,
	input  logic                   m68k_lds_n,
	input  logic                   m68k_rnw,
	output logic [`GEN_DATA_W-1:0] m68k_di,
	output logic                   m68k_dtack_n,
	output logic [`GEN_ADDR_W:1]   va,
	output logic [`GEN_DATA_W-1:0] vdo,
	input  logic [`GEN_DATA_W-1:0] vdi,
	output logic                   rnw,
	output logic                   uds_n,
	output logic                   lds_n,
	output logic                   asel_n,
	input  logic                   dtack_n,
	input  logic                   cart_n,
	output logic                   ce0_n,
	output logic                   rom_n,
	output logic                   ras2_n,
	output logic                   fdc_n,
	output logic                   wrl_n,
	output logic                   wrh_n,
	output logic                   oe_n,
	output logic                   ram_ce_n,
	input  logic                   ram_rdy,
	output logic                   rfs,
	input  logic                   rfs_rdy,
	mbus_if.arbiter                mbus,
	z80_ext_if.arbiter             ext
);

	localparam int RT_W = $clog2(`GEN_REFRESH_PERIOD);

	gen_bus_pkg::mbus_state_t mstate;
	gen_bus_pkg::mbus_src_t   msrc;
	logic [RT_W-1:0]          refresh_timer;
	logic                     rfs_pend;
	logic [`GEN_DATA_W-1:0]   open_bus;
	logic                     rom_act;
	logic                     ram_act;
	logic                     ctrl_act;
	logic                     fdc_act;

	// ------------------------------------------------------------------------
	// Arbitration FSM
	// ------------------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			mstate          <= gen_bus_pkg::MBUS_IDLE;
			msrc            <= gen_bus_pkg::SRC_NONE;
			m68k_dtack_n    <= 1'b1;
			ext.ext_dtack_n <= 1'b1;
			mbus.rnw        <= 1'b1;
			mbus.uds_n      <= 1'b1;
			mbus.lds_n      <= 1'b1;
			mbus.zbus_sel   <= 1'b0;
			mbus.ctrl_sel   <= 1'b0;
			asel_n          <= 1'b1;
			rom_act         <= 1'b0;
			ram_act         <= 1'b0;
			ctrl_act        <= 1'b0;
			fdc_act         <= 1'b0;
			open_bus        <= `GEN_OPEN_BUS_INIT;
			rfs             <= 1'b0;
			rfs_pend        <= 1'b0;
			refresh_timer   <= '0;
		end else begin
			mbus.ctrl_sel <= 1'b0;

			// Refresh becomes pending every period, served from idle
			refresh_timer <= refresh_timer + 1'b1;
			if (refresh_timer == RT_W'(`GEN_REFRESH_PERIOD - 1)) begin
				refresh_timer <= '0;
				rfs_pend      <= 1'b1;
			end

			case (mstate)
			gen_bus_pkg::MBUS_IDLE: begin
				msrc <= gen_bus_pkg::SRC_NONE;
				if (rfs_pend) begin
					rfs_pend <= 1'b0;
					rfs      <= 1'b1;
					mstate   <= gen_bus_pkg::MBUS_REFRESH;
				end else if (!m68k_as_n && (!m68k_uds_n || !m68k_lds_n) && m68k_dtack_n) begin
					msrc       <= gen_bus_pkg::SRC_M68K;
					mbus.addr  <= m68k_a;
					mbus.wdata <= m68k_do;
					mbus.uds_n <= m68k_uds_n;
					mbus.lds_n <= m68k_lds_n;
					mbus.rnw   <= m68k_rnw;
					asel_n     <= m68k_a[23];
					mstate     <= gen_bus_pkg::MBUS_SELECT;
				end else if (ext.ext_req && ext.ext_dtack_n) begin
					msrc       <= gen_bus_pkg::SRC_Z80;
					mbus.addr  <= ext.ext_addr;
					mbus.wdata <= ext.ext_wdata;
					// Z80 is byte wide, one lane per access
					mbus.uds_n <= ~ext.ext_upper;
					mbus.lds_n <= ext.ext_upper;
					mbus.rnw   <= ext.ext_rnw;
					asel_n     <= ext.ext_addr[23];
					mstate     <= gen_bus_pkg::MBUS_SELECT;
				end
			end

			gen_bus_pkg::MBUS_SELECT: begin
				// Anything not decoded completes with open-bus data
				mstate <= gen_bus_pkg::MBUS_NOT_USED;
				if (!mbus.addr[23]) begin
					rom_act <= 1'b1;
					mstate  <= gen_bus_pkg::MBUS_ROM_READ;
				end else if (mbus.addr[23:16] == `GEN_ZBUS_BASE) begin
					mbus.zbus_sel <= 1'b1;
					mstate        <= gen_bus_pkg::MBUS_ZBUS_READ;
				end else if (mbus.addr[23:12] == `GEN_CTRL_BASE && mbus.addr[7:1] == '0) begin
					mbus.ctrl_sel <= 1'b1;
					ctrl_act      <= 1'b1;
				end else if (mbus.addr[23:8] == `GEN_FDC_BASE) begin
					fdc_act <= 1'b1;
					mstate  <= gen_bus_pkg::MBUS_FDC_READ;
				end else if (&mbus.addr[23:21]) begin
					ram_act <= 1'b1;
					mstate  <= gen_bus_pkg::MBUS_RAM_WAIT;
				end
			end

			gen_bus_pkg::MBUS_RAM_WAIT: begin
				if (!ram_rdy) begin
					mstate <= mbus.rnw ? gen_bus_pkg::MBUS_RAM_READ : gen_bus_pkg::MBUS_RAM_WRITE;
				end
			end

			gen_bus_pkg::MBUS_RAM_READ: begin
				if (ram_rdy) begin
					m68k_dtack_n    <= (msrc != gen_bus_pkg::SRC_M68K);
					ext.ext_dtack_n <= (msrc != gen_bus_pkg::SRC_Z80);
					mstate          <= gen_bus_pkg::MBUS_FINISH;
				end
			end

			gen_bus_pkg::MBUS_ZBUS_READ: begin
				if (!mbus.zbus_dtack_n) begin
					m68k_dtack_n    <= (msrc != gen_bus_pkg::SRC_M68K);
					ext.ext_dtack_n <= (msrc != gen_bus_pkg::SRC_Z80);
					mstate          <= gen_bus_pkg::MBUS_FINISH;
				end
			end

			// Cartridge and FDC both answer on the external dtack
			gen_bus_pkg::MBUS_ROM_READ,
			gen_bus_pkg::MBUS_FDC_READ: begin
				if (!dtack_n) begin
					m68k_dtack_n    <= (msrc != gen_bus_pkg::SRC_M68K);
					ext.ext_dtack_n <= (msrc != gen_bus_pkg::SRC_Z80);
					mstate          <= gen_bus_pkg::MBUS_FINISH;
				end
			end

			gen_bus_pkg::MBUS_RAM_WRITE,
			gen_bus_pkg::MBUS_NOT_USED: begin
				m68k_dtack_n    <= (msrc != gen_bus_pkg::SRC_M68K);
				ext.ext_dtack_n <= (msrc != gen_bus_pkg::SRC_Z80);
				mstate          <= gen_bus_pkg::MBUS_FINISH;
			end

			gen_bus_pkg::MBUS_REFRESH: begin
				if (!rfs_rdy) begin
					rfs    <= 1'b0;
					mstate <= gen_bus_pkg::MBUS_IDLE;
				end
			end

			gen_bus_pkg::MBUS_FINISH: begin
				// Close once the owner has dropped its request
				if ((msrc == gen_bus_pkg::SRC_M68K && m68k_as_n && !m68k_dtack_n) ||
					(msrc == gen_bus_pkg::SRC_Z80 && !ext.ext_req && !ext.ext_dtack_n)) begin
					m68k_dtack_n    <= 1'b1;
					ext.ext_dtack_n <= 1'b1;
					mbus.rnw        <= 1'b1;
					mbus.uds_n      <= 1'b1;
					mbus.lds_n      <= 1'b1;
					mbus.zbus_sel   <= 1'b0;
					asel_n          <= 1'b1;
					rom_act         <= 1'b0;
					ram_act         <= 1'b0;
					ctrl_act        <= 1'b0;
					fdc_act         <= 1'b0;
					mstate          <= gen_bus_pkg::MBUS_IDLE;
					if (msrc == gen_bus_pkg::SRC_M68K) begin
						open_bus <= m68k_di;
					end
				end
			end

			default: mstate <= gen_bus_pkg::MBUS_IDLE;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// Read data and external strobes
	// ------------------------------------------------------------------------
	always_comb begin
		if (rom_act || ram_act || fdc_act) begin
			m68k_di = vdi;
		end else if (mbus.zbus_sel) begin
			m68k_di = {mbus.zbus_rdata, mbus.zbus_rdata};
		end else if (ctrl_act) begin
			// Only bit 8 is real, the rest floats
			m68k_di = {open_bus[15:9], mbus.ctrl_hit ? mbus.ctrl_flag : open_bus[8], open_bus[7:0]};
		end else begin
			m68k_di = open_bus;
		end
	end

	assign ext.ext_rdata = m68k_di;

	assign va    = mbus.addr;
	assign vdo   = mbus.wdata;
	assign rnw   = mbus.rnw;
	assign uds_n = mbus.uds_n;
	assign lds_n = mbus.lds_n;

	// Cartridge map swaps halves when cart_n is high
	assign ce0_n  = ~(va[23:22] == {1'b0, cart_n});
	assign rom_n  = ~(va[23:21] == {1'b0, ~cart_n, 1'b0});
	assign ras2_n = ~(va[23:21] == {1'b0, ~cart_n, 1'b1});
	assign fdc_n  = ~(va[23:8] == `GEN_FDC_BASE);

	assign ram_ce_n = ~ram_act;
	assign wrl_n    = mbus.rnw | mbus.lds_n;
	assign wrh_n    = mbus.rnw | mbus.uds_n;
	assign oe_n     = ~mbus.rnw;

endmodule

//--- zbus_ctrl.sv
// Z80 bus controller with work RAM arbitration, control and bank registers, used by the top
`timescale 1ns/1ps
`include "gen_bus_cfg.svh"

module zbus_ctrl (
	input  logic        MCLK,
	input  logic        reset,
	input  logic [15:0] z80_a,
	input  logic [7:0]  z80_do,
	input  logic        z80_mreq_n,
	input  logic        z80_rd_n,
	input  logic        z80_wr_n,
	input  logic        z80_busak_n,
	output logic [7:0]  z80_di,
	output logic        z80_wait_n,
	output logic        z80_busrq_n,
	output logic        z80_reset_n,
	mbus_if.zbus        mbus,
	z80_ext_if.zbus     ext
);

	gen_bus_pkg::zbus_state_t zstate;
	gen_bus_pkg::zbus_src_t   zsrc;
	logic [14:0]              zbus_a;
	logic [7:0]               zbus_wdata;
	logic                     zbus_we;
	logic [7:0]               zram_q;
	logic [7:0]               zbus_di;
	logic [7:0]               z80_zbus_d;
	logic                     z80_zbus_dtack_n;
	logic [`GEN_BANK_W-1:0]   bank;
	logic                     z80_io;
	logic                     z80_zbus;
	logic                     zbus_free;

	// Z80 memory cycle, and whether it stays in 0000h-7EFFh
	assign z80_io    = ~z80_mreq_n & (~z80_rd_n | ~z80_wr_n);
	assign z80_zbus  = ~z80_a[15] & ~&z80_a[14:8];
	assign zbus_free = ~z80_busrq_n & z80_reset_n;

	// Work RAM at 0000h-1FFFh with mirror, FM and the rest read FFh
	assign zbus_di = ~zbus_a[14] ? zram_q : 8'hFF;

	zram u_zram (
		.MCLK  (MCLK),
		.addr  (zbus_a[`GEN_ZRAM_AW-1:0]),
		.wdata (zbus_wdata),
		.we    (zbus_we & ~zbus_a[14]),
		.rdata (zram_q)
	);

	// ------------------------------------------------------------------------
	// Work RAM arbitration
	// ------------------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			zstate            <= gen_bus_pkg::ZBUS_IDLE;
			zbus_we           <= 1'b0;
			mbus.zbus_dtack_n <= 1'b1;
			z80_zbus_dtack_n  <= 1'b1;
		end else begin
			zbus_we <= 1'b0;
			if (!mbus.zbus_sel) begin
				mbus.zbus_dtack_n <= 1'b1;
			end
			if (!(z80_io && z80_zbus)) begin
				z80_zbus_dtack_n <= 1'b1;
			end

			case (zstate)
			gen_bus_pkg::ZBUS_IDLE: begin
				if (mbus.zbus_sel && mbus.zbus_dtack_n) begin
					zbus_a     <= {mbus.addr[14:1], mbus.uds_n};
					zbus_wdata <= !mbus.uds_n ? mbus.wdata[15:8] : mbus.wdata[7:0];
					// 68000 writes are dropped unless it owns the Z80 bus
					zbus_we    <= ~mbus.rnw & zbus_free;
					zsrc       <= gen_bus_pkg::ZSRC_MBUS;
					zstate     <= gen_bus_pkg::ZBUS_READ;
				end else if (z80_io && z80_zbus && z80_zbus_dtack_n) begin
					zbus_a     <= z80_a[14:0];
					zbus_wdata <= z80_do;
					zbus_we    <= ~z80_wr_n;
					zsrc       <= gen_bus_pkg::ZSRC_Z80;
					zstate     <= gen_bus_pkg::ZBUS_READ;
				end
			end

			gen_bus_pkg::ZBUS_READ: zstate <= gen_bus_pkg::ZBUS_FINISH;

			gen_bus_pkg::ZBUS_FINISH: begin
				if (zsrc == gen_bus_pkg::ZSRC_MBUS) begin
					mbus.zbus_rdata   <= zbus_free ? zbus_di : 8'hFF;
					mbus.zbus_dtack_n <= 1'b0;
				end else begin
					z80_zbus_d       <= zbus_di;
					z80_zbus_dtack_n <= 1'b0;
				end
				zstate <= gen_bus_pkg::ZBUS_IDLE;
			end

			default: zstate <= gen_bus_pkg::ZBUS_IDLE;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// Control and bank registers
	// ------------------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			z80_busrq_n <= 1'b1;
			z80_reset_n <= 1'b0;
			bank        <= '0;
		end else begin
			if (mbus.ctrl_sel && !mbus.rnw && !mbus.uds_n) begin
				if (mbus.addr[11:8] == 4'h1) begin
					z80_busrq_n <= ~mbus.wdata[8];
				end
				if (mbus.addr[11:8] == 4'h2) begin
					z80_reset_n <= mbus.wdata[8];
				end
			end
			// Bank loads serially, LSB of each write at 6000h enters at the top
			if (zbus_we && zbus_a[14:8] == 7'h60) begin
				bank <= {zbus_wdata[0], bank[`GEN_BANK_W-1:1]};
			end
		end
	end

	assign mbus.ctrl_hit  = (mbus.addr[11:8] == 4'h1) || (mbus.addr[11:8] == 4'h2);
	assign mbus.ctrl_flag = (mbus.addr[11:8] == 4'h1) ? (z80_busak_n | ~z80_reset_n) : z80_reset_n;

	// Z80 accesses outside its own window go out over the MBUS
	assign ext.ext_req   = z80_io & ~z80_zbus;
	assign ext.ext_addr  = z80_a[15] ? {bank, z80_a[14:1]} : {`GEN_VDP_WIN, z80_a[7:1]};
	assign ext.ext_wdata = {z80_do, z80_do};
	assign ext.ext_upper = ~z80_a[0];
	assign ext.ext_rnw   = z80_wr_n;

	assign z80_wait_n = ~z80_io | ~z80_zbus_dtack_n | ~ext.ext_dtack_n;
	assign z80_di     = !z80_zbus_dtack_n ? z80_zbus_d :
		(z80_a[0] ? ext.ext_rdata[7:0] : ext.ext_rdata[15:8]);

endmodule

//--- gen_bus_top.sv
// System bus core top level joining the MBUS arbiter and the ZBUS controller to the pins
`timescale 1ns/1ps
`include "gen_bus_cfg.svh"

module gen_bus_top (
	input  logic                   MCLK,
	input  logic                   reset,
	// 68000
	input  logic [`GEN_ADDR_W:1]   m68k_a,
	input  logic [`GEN_DATA_W-1:0] m68k_do,
	input  logic                   m68k_as_n,
	input  logic                   m68k_uds_n,
	input  logic                   m68k_lds_n,
	input  logic                   m68k_rnw,
	output logic [`GEN_DATA_W-1:0] m68k_di,
	output logic                   m68k_dtack_n,
	// Cartridge, FDC and work RAM bus
	output logic [`GEN_ADDR_W:1]   va,
	output logic [`GEN_DATA_W-1:0] vdo,
	input  logic [`GEN_DATA_W-1:0] vdi,
	output logic                   rnw,
	output logic                   uds_n,
	output logic                   lds_n,
	output logic                   asel_n,
	input  logic                   dtack_n,
	input  logic                   cart_n,
	output logic                   ce0_n,
	output logic                   rom_n,
	output logic                   ras2_n,
	output logic                   fdc_n,
	output logic                   wrl_n,
	output logic                   wrh_n,
	output logic                   oe_n,
	output logic                   ram_ce_n,
	input  logic                   ram_rdy,
	output logic                   rfs,
	input  logic                   rfs_rdy,
	// Z80
	input  logic [15:0]            z80_a,
	input  logic [7:0]             z80_do,
	input  logic                   z80_mreq_n,
	input  logic                   z80_rd_n,
	input  logic                   z80_wr_n,
	input  logic                   z80_busak_n,
	output logic [7:0]             z80_di,
	output logic                   z80_wait_n,
	output logic                   z80_busrq_n,
	output logic                   z80_reset_n
);

	mbus_if    u_mbus ();
	z80_ext_if u_ext ();

	mbus_arbiter u_mbus_arbiter (
		.mbus (u_mbus.arbiter),
		.ext  (u_ext.arbiter),
		.*
	);

	zbus_ctrl u_zbus_ctrl (
		.mbus (u_mbus.zbus),
		.ext  (u_ext.zbus),
		.*
	);

endmodule

//--- tb_gen_bus.sv
// Self-checking testbench for the bus core, run as the simulation top with the file list
`timescale 1ns/1ps
`include "gen_bus_cfg.svh"

module tb_gen_bus;

	logic        MCLK;
	logic        reset;
	logic [23:1] m68k_a;
	logic [15:0] m68k_do;
	logic        m68k_as_n, m68k_uds_n, m68k_lds_n, m68k_rnw;
	logic [15:0] m68k_di;
	logic        m68k_dtack_n;
	logic [23:1] va;
	logic [15:0] vdo, vdi;
	logic        rnw, uds_n, lds_n, asel_n, dtack_n, cart_n;
	logic        ce0_n, rom_n, ras2_n, fdc_n, wrl_n, wrh_n, oe_n, ram_ce_n;
	logic        ram_rdy, rfs, rfs_rdy;
	logic [15:0] z80_a;
	logic [7:0]  z80_do, z80_di;
	logic        z80_mreq_n, z80_rd_n, z80_wr_n, z80_busak_n;
	logic        z80_wait_n, z80_busrq_n, z80_reset_n;

	// Shadow state for the reference model
	logic [7:0]  zram_sh [0:(1 << `GEN_ZRAM_AW) - 1];
	logic [15:0] ob_sh;
	logic        busrq_sh, zrst_sh;
	logic [8:0]  bank_sh;
	logic        rfs_d1, rfs_d2, rfs_prev, rfs_mon;
	int          rfs_gap, rfs_pulses;
	int          mismatch_cnt, other_cnt;
	logic [15:0] got_q [$];
	logic [15:0] exp_q [$];
	string       what_q [$];

	gen_bus_top u_gen_bus_top (.*);

	initial begin
		MCLK = 1'b0;
		forever #5 MCLK = ~MCLK;
	end

	// Cartridge word for any address
	function automatic logic [15:0] cart_word(input logic [23:1] a);
		return a[16:1] ^ {a[23:17], a[23:17], 2'b01};
	endfunction

	// Expected 68000 read data from the region rules
	function automatic logic [15:0] expect_read(input logic [23:1] a, input logic us);
		logic [7:0] b;
		logic       flag;
		if (!a[23]) begin
			return cart_word(a);
		end
		if (a[23:16] == 8'hA0) begin
			if (busrq_sh || !zrst_sh || a[14]) begin
				return 16'hFFFF;
			end
			b = zram_sh[{a[12:1], us}];
			return {b, b};
		end
		if (a[23:12] == 12'hA11 && a[7:1] == 7'd0) begin
			flag = ob_sh[8];
			if (a[11:8] == 4'h1) flag = z80_busak_n;
			if (a[11:8] == 4'h2) flag = zrst_sh;
			return {ob_sh[15:9], flag, ob_sh[7:0]};
		end
		if (a[23:8] == 16'hA120) begin
			return cart_word(a);
		end
		// Work RAM shares the cartridge bus model
		if (&a[23:21]) begin
			return cart_word(a);
		end
		return ob_sh;
	endfunction

	// ------------------------------------------------------------------------
	// Bus models, updated on the falling edge
	// ------------------------------------------------------------------------
	always @(negedge MCLK) begin
		dtack_n     <= asel_n & fdc_n;
		vdi         <= cart_word(va);
		ram_rdy     <= ram_ce_n ? 1'b1 : ~ram_rdy;
		rfs_d1      <= rfs;
		rfs_d2      <= rfs_d1;
		rfs_rdy     <= ~rfs_d2;
		z80_busak_n <= z80_busrq_n;
	end

	// Compare process
	always @(posedge MCLK) begin
		while (got_q.size() > 0) begin
			assert (got_q[0] == exp_q[0]) else begin
				mismatch_cnt++;
				$display("Mismatch at %0t: %s got %h expected %h",
					$time, what_q[0], got_q[0], exp_q[0]);
			end
			void'(got_q.pop_front());
			void'(exp_q.pop_front());
			void'(what_q.pop_front());
		end
	end

	// Refresh spacing while idle, and never inside an acknowledged cycle
	always @(posedge MCLK) begin
		rfs_prev <= rfs;
		if (!reset) begin
			assert (!(rfs && !m68k_dtack_n)) else begin
				other_cnt++;
				$display("Refresh overlapped a 68000 cycle at %0t", $time);
			end
		end
		if (reset || !rfs_mon) begin
			rfs_gap <= 0;
		end else if (rfs && !rfs_prev) begin
			rfs_gap    <= 0;
			rfs_pulses <= rfs_pulses + 1;
		end else begin
			rfs_gap <= rfs_gap + 1;
			assert (rfs_gap < 400) else begin
				other_cnt++;
				$display("No refresh within 400 idle cycles at %0t", $time);
			end
		end
	end

	task automatic push_check(input string what, input logic [15:0] got, input logic [15:0] exp);
		got_q.push_back(got);
		exp_q.push_back(exp);
		what_q.push_back(what);
	endtask

	task automatic timeout_fail(input string what);
		$display("Timed out waiting for %s at %0t", what, $time);
		$display("Errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt + 1);
		$display("Simulation failed");
		$finish;
	endtask

	task automatic wait_dtack(input logic level);
		int n;
		n = 0;
		while (m68k_dtack_n != level) begin
			@(negedge MCLK);
			n++;
			if (n > 300) timeout_fail("68000 dtack");
		end
	endtask

	task automatic m68k_cycle(input logic [23:0] ba, input logic us, input logic ls,
		input logic wr, input logic [15:0] wd, output logic [15:0] rd);
		@(negedge MCLK);
		m68k_a     = ba[23:1];
		m68k_do    = wd;
		m68k_rnw   = ~wr;
		m68k_uds_n = us;
		m68k_lds_n = ls;
		m68k_as_n  = 1'b0;
		wait_dtack(1'b0);
		rd = m68k_di;
		// Bus outputs of the accepted cycle
		assert (va == ba[23:1] && vdo == wd && rnw == ~wr && asel_n == ba[23] &&
			uds_n == us && lds_n == ls) else begin
			other_cnt++;
			$display("Bus address, data or byte lanes wrong at %0t", $time);
		end
		assert (wrh_n == (~wr | us) && wrl_n == (~wr | ls) && oe_n == wr) else begin
			other_cnt++;
			$display("Write or output enable strobes wrong at %0t", $time);
		end
		// Chip selects with a cartridge present
		assert (ce0_n == (ba[23:22] != 2'b00) && rom_n == (ba[23:21] != 3'b010) &&
			ras2_n == (ba[23:21] != 3'b011) && ram_ce_n == !(&ba[23:21]) &&
			fdc_n == (ba[23:8] != 16'hA120)) else begin
			other_cnt++;
			$display("Chip selects wrong at %0t", $time);
		end
		@(negedge MCLK);
		m68k_as_n  = 1'b1;
		m68k_uds_n = 1'b1;
		m68k_lds_n = 1'b1;
		m68k_rnw   = 1'b1;
		wait_dtack(1'b1);
	endtask

	task automatic read_check(input string what, input logic [23:0] ba, input logic us, input logic ls);
		logic [15:0] exp;
		logic [15:0] got;
		exp = expect_read(ba[23:1], us);
		m68k_cycle(ba, us, ls, 1'b0, 16'h0000, got);
		push_check(what, got, exp);
		ob_sh = exp;
	endtask

	task automatic write_word(input logic [23:0] ba, input logic us, input logic ls, input logic [15:0] d);
		logic [15:0] unused;
		logic        granted;
		granted = ~busrq_sh & zrst_sh;
		m68k_cycle(ba, us, ls, 1'b1, d, unused);
		if (ba[23:12] == 12'hA11 && ba[7:1] == 7'd0 && !us) begin
			if (ba[11:8] == 4'h1) busrq_sh = ~d[8];
			if (ba[11:8] == 4'h2) zrst_sh = d[8];
		end
		if (ba[23:16] == 8'hA0 && granted && !ba[14]) begin
			zram_sh[{ba[12:1], us}] = us ? d[7:0] : d[15:8];
		end
		// A write leaves the open-bus latch with its own data, so a cartridge read resets it
		read_check("cart resync read", 24'h000000, 1'b0, 1'b0);
	endtask

	task automatic z80_access(input logic [15:0] a, input logic wr, input logic [7:0] d,
		output logic [7:0] rd, output logic [23:1] seen_va);
		int n;
		@(negedge MCLK);
		z80_a      = a;
		z80_do     = d;
		z80_mreq_n = 1'b0;
		z80_rd_n   = wr;
		z80_wr_n   = ~wr;
		n = 0;
		do begin
			@(negedge MCLK);
			n++;
			if (n > 300) timeout_fail("Z80 wait release");
		end while (!z80_wait_n);
		rd      = z80_di;
		seen_va = va;
		z80_mreq_n = 1'b1;
		z80_rd_n   = 1'b1;
		z80_wr_n   = 1'b1;
	endtask

	initial begin
		logic [23:0] ba;
		logic [7:0]  zd;
		logic [7:0]  zr;
		logic [23:1] sva;
		logic [23:1] exp_va;
		logic [15:0] cw;
		logic        us;
		void'($urandom(32'h8c5bf8f0));
		reset = 1'b1;
		m68k_a = '0;
		m68k_do = '0;
		m68k_as_n = 1'b1;
		m68k_uds_n = 1'b1;
		m68k_lds_n = 1'b1;
		m68k_rnw = 1'b1;
		vdi = '0;
		dtack_n = 1'b1;
		cart_n = 1'b0;
		ram_rdy = 1'b1;
		rfs_rdy = 1'b1;
		rfs_d1 = 1'b0;
		rfs_d2 = 1'b0;
		z80_a = '0;
		z80_do = '0;
		z80_mreq_n = 1'b1;
		z80_rd_n = 1'b1;
		z80_wr_n = 1'b1;
		z80_busak_n = 1'b1;
		rfs_mon = 1'b0;
		rfs_pulses = 0;
		mismatch_cnt = 0;
		other_cnt = 0;
		ob_sh = `GEN_OPEN_BUS_INIT;
		busrq_sh = 1'b1;
		zrst_sh = 1'b0;
		bank_sh = '0;
		for (int i = 0; i < (1 << `GEN_ZRAM_AW); i++) zram_sh[i] = 8'h00;
		repeat (16) @(negedge MCLK);
		reset = 1'b0;
		@(negedge MCLK);

		// Reset state
		assert (m68k_dtack_n && ram_ce_n && z80_busrq_n && !rfs && !z80_reset_n &&
			asel_n && wrl_n && wrh_n) else begin
			other_cnt++;
			$display("Outputs not in their reset state at %0t", $time);
		end
		read_check("first unmapped read", 24'hC00000, 1'b0, 1'b0);

		// Take the Z80 bus and store a known byte
		write_word(24'hA11100, 1'b0, 1'b0, 16'h0100);
		write_word(24'hA11200, 1'b0, 1'b0, 16'h0100);
		write_word(24'hA00010, 1'b0, 1'b1, 16'hC300);

		// Released bus reads FFh and drops writes
		write_word(24'hA11100, 1'b0, 1'b0, 16'h0000);
		write_word(24'hA00010, 1'b0, 1'b1, 16'h5A00);
		read_check("ungranted zbus read", 24'hA00010, 1'b0, 1'b0);

		write_word(24'hA11100, 1'b0, 1'b0, 16'h0100);
		repeat (4) @(negedge MCLK);
		read_check("busreq status", 24'hA11100, 1'b0, 1'b0);
		read_check("lost write readback", 24'hA00010, 1'b0, 1'b1);
		for (int i = 0; i < 12; i++) begin
			ba = {8'hA0, 3'b000, 13'($urandom())};
			us = ba[0];
			ba[0] = 1'b0;
			zd = 8'($urandom());
			write_word(ba, us, ~us, {zd, zd});
			read_check("zbus byte readback", ba, us, ~us);
		end

		// Cartridge reads and writes, each followed by an open-bus read
		for (int i = 0; i < 10; i++) begin
			ba = {1'b0, 22'($urandom()), 1'b0};
			read_check("cart read", ba, 1'b0, 1'b0);
			read_check("open bus after read", 24'hC00000, 1'b0, 1'b0);
			us = 1'($urandom());
			write_word({1'b0, 22'($urandom()), 1'b0}, us, us ? 1'b0 : 1'($urandom()), 16'($urandom()));
		end

		// Work RAM and FDC cycles on the same bus
		for (int i = 0; i < 4; i++) begin
			read_check("work ram read", {3'b111, 20'($urandom()), 1'b0}, 1'b0, 1'b0);
			read_check("fdc read", {16'hA120, 7'($urandom()), 1'b0}, 1'b0, 1'b0);
			read_check("open bus after read", 24'hC00000, 1'b0, 1'b0);
			write_word({3'b111, 20'($urandom()), 1'b0}, 1'b0, 1'b0, 16'($urandom()));
		end

		// Z80 loads the bank register, the last bit kept low to stay in cartridge space
		for (int i = 0; i < 9; i++) begin
			zd = (i == 8) ? 8'h00 : 8'($urandom());
			z80_access(16'h6000, 1'b1, zd, zr, sva);
			bank_sh = {zd[0], bank_sh[8:1]};
		end
		for (int i = 0; i < 8; i++) begin
			z80_a = 16'h8000 | 16'($urandom());
			exp_va = {bank_sh, z80_a[14:1]};
			cw = cart_word(exp_va);
			z80_access(z80_a, 1'b0, 8'h00, zd, sva);
			push_check("banked va", sva[16:1], exp_va[16:1]);
			push_check("banked va high", {9'd0, sva[23:17]}, {9'd0, exp_va[23:17]});
			push_check("z80 banked byte", {8'd0, zd}, {8'd0, z80_a[0] ? cw[7:0] : cw[15:8]});
		end

		// Idle window for refresh spacing
		rfs_mon = 1'b1;
		repeat (1200) @(negedge MCLK);
		rfs_mon = 1'b0;
		assert (rfs_pulses >= 2) else begin
			other_cnt++;
			$display("Too few refresh pulses while idle");
		end

		repeat (4) @(negedge MCLK);
		$display("Errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
		if (mismatch_cnt == 0 && other_cnt == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- list.f
+incdir+.
gen_bus_pkg.sv
mbus_if.sv
z80_ext_if.sv
zram.sv
mbus_arbiter.sv
zbus_ctrl.sv
gen_bus_top.sv
tb_gen_bus.sv
